// ==== logic/cam_pkg.sv ====
`default_nettype none

package cam_pkg;

    // --------------------------------------------------
    // frame timing states
    // --------------------------------------------------
    typedef enum logic [4:0] {
        RST,
        SOF,        // vsync high
        WAIT_SOF,   // blanking before the first line
        SEND_LINE,  // href high, pixels back to back
        WAIT_EOF    // blanking after the last line
    } cam_state_e;

    // --------------------------------------------------
    // test pattern opcodes
    // --------------------------------------------------
    typedef enum logic [1:0] {
        PAT_RAMP    = 2'd0,
        PAT_BARS    = 2'd1,
        PAT_CHECKER = 2'd2
    } cam_pattern_e;

    // interval timer and coordinate width
    localparam int CNT_W = 16;

    // blanking pixels added to HRES for one line time
    localparam int LINE_OVERHEAD = 144;

    // interval lengths in line times
    localparam int SOF_LINES      = 3;
    localparam int WAIT_SOF_LINES = 17;
    localparam int WAIT_EOF_LINES = 10;

endpackage

`default_nettype wire

// ==== logic/cam_pix_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cam_pix_if;

    logic                      vsync;    // frame strobe level
    logic                      href;     // line valid level
    logic                      bytesel;  // 0 = high byte, 1 = low byte
    logic [cam_pkg::CNT_W-1:0] col;
    logic [cam_pkg::CNT_W-1:0] line;
    logic                      frame;    // frame parity
    logic [23:0]               rgb;      // RGB888, only meaningful after the pattern stage

    modport src (
        output vsync, href, bytesel, col, line, frame, rgb
    );

    modport dst (
        input  vsync, href, bytesel, col, line, frame, rgb
    );

endinterface

`default_nettype wire

// ==== logic/cam_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_timing_gen #(
    parameter int HRES = 640,
    parameter int VRES = 480
) (
    input  logic   cam_pclk_o,
    input  logic   s_rstn,
    input  logic   en_i,
    cam_pix_if.src tim_o
);

    typedef logic [cam_pkg::CNT_W-1:0] cnt_t;

    localparam int TLINE = (HRES + cam_pkg::LINE_OVERHEAD) * 2;  // two bytes per pixel

    // timer load values, the state ends on the cycle the timer reads zero
    localparam cnt_t SOF_CNT      = cnt_t'(cam_pkg::SOF_LINES * TLINE - 1);
    localparam cnt_t WAIT_SOF_CNT = cnt_t'(cam_pkg::WAIT_SOF_LINES * TLINE - 1);
    localparam cnt_t WAIT_EOF_CNT = cnt_t'(cam_pkg::WAIT_EOF_LINES * TLINE - 1);

    localparam cnt_t COL_LAST  = cnt_t'(HRES - 1);
    localparam cnt_t LINE_LAST = cnt_t'(VRES - 1);

    cam_pkg::cam_state_e state_q, state_d;
    cnt_t                timer_q, timer_d;
    cnt_t                col_q, col_d;
    cnt_t                line_q, line_d;
    logic                bytesel_q, bytesel_d;
    logic                frame_q, frame_d;
    logic                timer_done;

    assign timer_done = (timer_q == '0);

    // --------------------------------------------------
    // next state
    // --------------------------------------------------
    always_comb begin
        state_d   = state_q;
        col_d     = col_q;
        line_d    = line_q;
        bytesel_d = bytesel_q;
        frame_d   = frame_q;
        timer_d   = timer_done ? timer_q : timer_q - 1'b1;  // free countdown to zero

        case (state_q)
            cam_pkg::RST: begin
                state_d   = cam_pkg::SOF;
                timer_d   = SOF_CNT;
                col_d     = '0;
                line_d    = '0;
                bytesel_d = 1'b0;
                frame_d   = 1'b0;  // always start on an even frame
            end
            cam_pkg::SOF: begin
                if (timer_done) begin
                    state_d = cam_pkg::WAIT_SOF;
                    timer_d = WAIT_SOF_CNT;
                end
            end
            cam_pkg::WAIT_SOF: begin
                if (timer_done) begin
                    state_d   = cam_pkg::SEND_LINE;
                    col_d     = '0;
                    line_d    = '0;
                    bytesel_d = 1'b0;
                end
            end
            cam_pkg::SEND_LINE: begin
                bytesel_d = ~bytesel_q;
                if (bytesel_q) begin  // low byte done, next pixel
                    if (col_q == COL_LAST) begin
                        col_d = '0;
                        if (line_q == LINE_LAST) begin
                            state_d = cam_pkg::WAIT_EOF;
                            timer_d = WAIT_EOF_CNT;
                            line_d  = '0;
                        end else begin
                            line_d = line_q + 1'b1;
                        end
                    end else begin
                        col_d = col_q + 1'b1;
                    end
                end
            end
            cam_pkg::WAIT_EOF: begin
                if (timer_done) begin
                    state_d = cam_pkg::SOF;
                    timer_d = SOF_CNT;
                    frame_d = ~frame_q;
                end
            end
            default: state_d = cam_pkg::RST;
        endcase
    end

    // --------------------------------------------------
    // state registers, en_i low holds the reset state
    // --------------------------------------------------
    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            state_q   <= cam_pkg::RST;
            timer_q   <= '0;
            col_q     <= '0;
            line_q    <= '0;
            bytesel_q <= 1'b0;
            frame_q   <= 1'b0;
        end else if (!en_i) begin
            state_q   <= cam_pkg::RST;
            timer_q   <= '0;
            col_q     <= '0;
            line_q    <= '0;
            bytesel_q <= 1'b0;
            frame_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            timer_q   <= timer_d;
            col_q     <= col_d;
            line_q    <= line_d;
            bytesel_q <= bytesel_d;
            frame_q   <= frame_d;
        end
    end

    // outputs straight from the state registers
    assign tim_o.vsync   = (state_q == cam_pkg::SOF);
    assign tim_o.href    = (state_q == cam_pkg::SEND_LINE);
    assign tim_o.bytesel = bytesel_q;  // stays 0 outside SEND_LINE
    assign tim_o.col     = col_q;
    assign tim_o.line    = line_q;
    assign tim_o.frame   = frame_q;
    assign tim_o.rgb     = '0;         // no pixel yet at this stage

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    a_sync_excl: assert property (@(posedge cam_pclk_o) disable iff (!s_rstn)
        !(tim_o.vsync && tim_o.href))
        else $error("vsync and href high together");

    a_byte_toggle: assert property (@(posedge cam_pclk_o) disable iff (!s_rstn)
        (tim_o.href && $past(tim_o.href)) |-> (tim_o.bytesel != $past(tim_o.bytesel)))
        else $error("bytesel did not toggle inside href");

endmodule

`default_nettype wire

// ==== logic/cam_pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_pattern_gen #(
    parameter int HRES = 640
) (
    input  logic                  cam_pclk_o,
    input  logic                  s_rstn,
    input  cam_pkg::cam_pattern_e pattern_sel_i,
    cam_pix_if.dst                tim_i,
    cam_pix_if.src                pix_o
);

    logic                  vsync_q;
    cam_pkg::cam_pattern_e pat_q;     // pattern of the current frame
    logic [31:0]           bar_num;
    logic [2:0]            bar_idx;
    logic [2:0]            bar_rgb;   // one bit per channel
    logic                  chk_white;
    logic [23:0]           rgb_d;

    // one bit per channel to full 8-bit channels
    function automatic logic [23:0] expand_rgb(input logic [2:0] c);
        return {{8{c[2]}}, {8{c[1]}}, {8{c[0]}}};
    endfunction

    // --------------------------------------------------
    // pixel from coordinates
    // --------------------------------------------------
    assign bar_num   = (32'(tim_i.col) << 3) / HRES;
    assign bar_idx   = bar_num[2:0];
    assign chk_white = tim_i.col[2] ^ tim_i.line[2] ^ tim_i.frame;

    always_comb begin
        case (bar_idx)
            3'd0:    bar_rgb = 3'b111;  // white
            3'd1:    bar_rgb = 3'b110;  // yellow
            3'd2:    bar_rgb = 3'b011;  // cyan
            3'd3:    bar_rgb = 3'b010;  // green
            3'd4:    bar_rgb = 3'b101;  // magenta
            3'd5:    bar_rgb = 3'b100;  // red
            3'd6:    bar_rgb = 3'b001;  // blue
            default: bar_rgb = 3'b000;  // black
        endcase
    end

    always_comb begin
        case (pat_q)
            cam_pkg::PAT_RAMP:
                rgb_d = {tim_i.col[7:0], tim_i.line[7:0], {8{tim_i.frame}}};
            cam_pkg::PAT_BARS:
                rgb_d = expand_rgb(bar_rgb);
            cam_pkg::PAT_CHECKER:
                rgb_d = expand_rgb({3{chk_white}});
            default:
                rgb_d = '0;
        endcase
    end

    // --------------------------------------------------
    // pattern latch and sync pipeline
    // --------------------------------------------------
    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            vsync_q       <= 1'b0;
            pat_q         <= cam_pkg::PAT_RAMP;
            pix_o.vsync   <= 1'b0;
            pix_o.href    <= 1'b0;
            pix_o.bytesel <= 1'b0;
            pix_o.frame   <= 1'b0;
        end else begin
            vsync_q <= tim_i.vsync;
            if (tim_i.vsync && !vsync_q) begin  // new frame starts
                pat_q <= pattern_sel_i;
            end
            pix_o.vsync   <= tim_i.vsync;
            pix_o.href    <= tim_i.href;
            pix_o.bytesel <= tim_i.bytesel;
            pix_o.frame   <= tim_i.frame;
        end
    end

    // payload
    always_ff @(posedge cam_pclk_o) begin
        pix_o.col  <= tim_i.col;
        pix_o.line <= tim_i.line;
        pix_o.rgb  <= rgb_d;
    end

endmodule

`default_nettype wire

// ==== logic/cam_rgb565_ser.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_rgb565_ser (
    input  logic       cam_pclk_o,
    input  logic       s_rstn,
    cam_pix_if.dst     pix_i,
    output logic       cam_vsync_o,
    output logic       cam_href_o,
    output logic [7:0] cam_data_o
);

    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
    logic [7:0] byte_hi;
    logic [7:0] byte_lo;
    logic [7:0] byte_d;

    // --------------------------------------------------
    // RGB888 to RGB565
    // --------------------------------------------------
    assign r5 = pix_i.rgb[23:19];
    assign g6 = pix_i.rgb[15:10];
    assign b5 = pix_i.rgb[7:3];

    assign byte_hi = {r5, g6[5:3]};  // sent first
    assign byte_lo = {g6[2:0], b5};

    always_comb begin
        if (!pix_i.href) begin
            byte_d = 8'h00;  // bus idles at zero
        end else if (pix_i.bytesel) begin
            byte_d = byte_lo;
        end else begin
            byte_d = byte_hi;
        end
    end

    // --------------------------------------------------
    // output registers
    // --------------------------------------------------
    always_ff @(posedge cam_pclk_o or negedge s_rstn) begin
        if (!s_rstn) begin
            cam_vsync_o <= 1'b0;
            cam_href_o  <= 1'b0;
            cam_data_o  <= 8'h00;
        end else begin
            cam_vsync_o <= pix_i.vsync;
            cam_href_o  <= pix_i.href;
            cam_data_o  <= byte_d;
        end
    end

    a_data_idle: assert property (@(posedge cam_pclk_o) disable iff (!s_rstn)
        !cam_href_o |-> (cam_data_o == 8'h00))
        else $error("data not zero outside href");

endmodule

`default_nettype wire

// ==== logic/cam_sensor_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_sensor_top #(
    parameter int HRES = 640,
    parameter int VRES = 480
) (
    input  logic       cam_pclk_o,
    input  logic       s_rstn,
    input  logic       en_i,
    input  logic [1:0] pattern_sel_i,
    output logic       cam_vsync_o,
    output logic       cam_href_o,
    output logic [7:0] cam_data_o
);

    cam_pix_if tim_if ();  // timing to pattern
    cam_pix_if pix_if ();  // pattern to serializer

    // --------------------------------------------------
    // pipeline: timing, pattern, serializer
    // --------------------------------------------------
    cam_timing_gen #(
        .HRES (HRES),
        .VRES (VRES)
    ) u_timing (
        .cam_pclk_o (cam_pclk_o),
        .s_rstn     (s_rstn),
        .en_i       (en_i),
        .tim_o      (tim_if.src)
    );

    cam_pattern_gen #(
        .HRES (HRES)
    ) u_pattern (
        .cam_pclk_o    (cam_pclk_o),
        .s_rstn        (s_rstn),
        .pattern_sel_i (cam_pkg::cam_pattern_e'(pattern_sel_i)),
        .tim_i         (tim_if.dst),
        .pix_o         (pix_if.src)
    );

    cam_rgb565_ser u_ser (
        .cam_pclk_o  (cam_pclk_o),
        .s_rstn      (s_rstn),
        .pix_i       (pix_if.dst),
        .cam_vsync_o (cam_vsync_o),
        .cam_href_o  (cam_href_o),
        .cam_data_o  (cam_data_o)
    );

endmodule

`default_nettype wire

// ==== tb/tb_cam_sensor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cam_sensor;

    localparam int HRES         = 16;
    localparam int VRES         = 8;
    localparam int TLINE        = (HRES + 144) * 2;  // 320 cycles
    localparam int SOF_CYC      = 3 * TLINE;
    localparam int WAIT_SOF_CYC = 17 * TLINE;
    localparam int ACTIVE_CYC   = HRES * VRES * 2;
    localparam int WAIT_EOF_CYC = 10 * TLINE;
    localparam int FRAME_CYC    = SOF_CYC + WAIT_SOF_CYC + ACTIVE_CYC + WAIT_EOF_CYC;
    localparam int TIMEOUT_CYC  = 5 * FRAME_CYC + 720;  // four frames plus restart
    localparam int MID_LINE     = 100;                  // offset into href for changes

    // checker phases
    localparam int PH_IDLE  = 0;
    localparam int PH_VSYNC = 1;
    localparam int PH_SOF   = 2;
    localparam int PH_LINE  = 3;
    localparam int PH_EOF   = 4;

    logic       cam_pclk_o;
    logic       s_rstn;
    logic       en_i;
    logic [1:0] pattern_sel;
    logic       cam_vsync_o;
    logic       cam_href_o;
    logic [7:0] cam_data_o;

    int         err_count = 0;
    int         bytes_checked = 0;
    int         ramp_frames = 0;
    int         bars_frames = 0;
    int         checker_frames = 0;
    int         aborted_frames = 0;
    int         cycle_cnt = 0;
    int         phase, cnt, exp_col, exp_row, en_low_cnt;
    logic       exp_bsel, exp_frame, first_frame, vsync_q;
    logic [1:0] exp_pat;

    cam_sensor_top #(
        .HRES (HRES),
        .VRES (VRES)
    ) u_dut (
        .cam_pclk_o    (cam_pclk_o),
        .s_rstn        (s_rstn),
        .en_i          (en_i),
        .pattern_sel_i (pattern_sel),
        .cam_vsync_o   (cam_vsync_o),
        .cam_href_o    (cam_href_o),
        .cam_data_o    (cam_data_o)
    );

    initial begin
        cam_pclk_o = 1'b0;
        forever #5 cam_pclk_o = ~cam_pclk_o;
    end

    // expected byte from the pattern rules and RGB565 packing
    function automatic logic [7:0] ref_byte(input logic [1:0] pat, input int col,
                                            input int row, input logic frame,
                                            input logic bsel);
        logic [7:0]  r, g, b;
        logic [15:0] cv, rv;
        logic        white;
        cv = 16'(col);
        rv = 16'(row);
        {r, g, b} = 24'h000000;
        case (pat)
            cam_pkg::PAT_RAMP: begin
                r = cv[7:0];
                g = rv[7:0];
                b = frame ? 8'hff : 8'h00;  // blue flips every frame
            end
            cam_pkg::PAT_BARS: begin
                case ((col * 8) / HRES)
                    0:       {r, g, b} = 24'hffffff;
                    1:       {r, g, b} = 24'hffff00;
                    2:       {r, g, b} = 24'h00ffff;
                    3:       {r, g, b} = 24'h00ff00;
                    4:       {r, g, b} = 24'hff00ff;
                    5:       {r, g, b} = 24'hff0000;
                    6:       {r, g, b} = 24'h0000ff;
                    default: {r, g, b} = 24'h000000;
                endcase
            end
            cam_pkg::PAT_CHECKER: begin
                white = cv[2] ^ rv[2] ^ frame;
                r = white ? 8'hff : 8'h00;
                g = r;
                b = r;
            end
            default: ;
        endcase
        if (bsel) begin
            return {g[4:2], b[7:3]};
        end
        return {r[7:3], g[7:5]};  // high byte goes first
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_count++;
        $display("[ERROR] t=%0t %s expected=%0d (0x%0h) actual=%0d (0x%0h)",
                 $time, name, expected, expected, actual, actual);
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("t=%0t failure: %s", $time, what);
    endtask

    task automatic print_counts;
        $display("errors=%0d bytes=%0d ramp=%0d bars=%0d checker=%0d aborted=%0d",
                 err_count, bytes_checked, ramp_frames, bars_frames, checker_frames,
                 aborted_frames);
    endtask

    task automatic check_pixel_byte;
        logic [7:0] exp_byte;
        exp_byte = ref_byte(exp_pat, exp_col, exp_row, exp_frame, exp_bsel);
        if (cam_data_o !== exp_byte) report_mismatch("cam_data_o", 32'(exp_byte),
                                                     32'(cam_data_o));
        bytes_checked++;
        cnt++;
        if (exp_bsel) begin  // pixel done
            if (exp_col == HRES - 1) begin
                exp_col = 0;
                exp_row++;
            end else begin
                exp_col++;
            end
        end
        exp_bsel = ~exp_bsel;
    endtask

    task automatic wait_href_start;
        @(posedge cam_href_o);
        @(negedge cam_pclk_o);
    endtask

    // --------------------------------------------------
    // checker, samples the registered DUT outputs
    // --------------------------------------------------
    always @(posedge cam_pclk_o) begin
        if (!s_rstn) begin
            phase       = PH_IDLE;
            cnt         = 0;
            en_low_cnt  = 0;
            first_frame = 1'b1;
            vsync_q     = 1'b0;
        end else begin
            if (!en_i) begin
                if (en_low_cnt == 0 && phase == PH_LINE) aborted_frames++;
                en_low_cnt++;
                phase       = PH_IDLE;
                first_frame = 1'b1;  // parity restarts at even
            end else begin
                en_low_cnt = 0;
            end
            if (en_low_cnt > 3) begin  // pipeline has drained
                if (cam_vsync_o !== 1'b0) report_mismatch("cam_vsync_o", 0, 32'(cam_vsync_o));
                if (cam_href_o !== 1'b0) report_mismatch("cam_href_o", 0, 32'(cam_href_o));
            end
            if (cam_vsync_o && cam_href_o) report_failure("vsync and href high together");
            if (!cam_href_o && cam_data_o !== 8'h00) report_mismatch("cam_data_o", 0,
                                                                     32'(cam_data_o));
            if (cam_vsync_o && !vsync_q) begin  // start of frame
                if (phase == PH_EOF && cnt != WAIT_EOF_CYC) begin
                    report_mismatch("cam_href_o to cam_vsync_o gap", WAIT_EOF_CYC, cnt);
                end
                if (phase != PH_EOF && phase != PH_IDLE) report_failure("vsync rose mid-frame");
                exp_frame   = first_frame ? 1'b0 : ~exp_frame;
                first_frame = 1'b0;
                exp_pat     = pattern_sel;
                phase       = PH_VSYNC;
                cnt         = 1;
            end else begin
                case (phase)
                    PH_VSYNC: begin
                        if (cam_vsync_o) begin
                            cnt++;
                        end else begin
                            if (cnt != SOF_CYC) report_mismatch("cam_vsync_o high cycles",
                                                                SOF_CYC, cnt);
                            phase = PH_SOF;
                            cnt   = 1;
                        end
                    end
                    PH_SOF: begin
                        if (cam_href_o) begin
                            if (cnt != WAIT_SOF_CYC) begin
                                report_mismatch("cam_vsync_o to cam_href_o gap",
                                                WAIT_SOF_CYC, cnt);
                            end
                            phase    = PH_LINE;
                            cnt      = 0;
                            exp_col  = 0;
                            exp_row  = 0;
                            exp_bsel = 1'b0;
                            check_pixel_byte();
                        end else begin
                            cnt++;
                        end
                    end
                    PH_LINE: begin
                        if (cam_href_o) begin
                            check_pixel_byte();
                        end else begin
                            if (cnt != ACTIVE_CYC) report_mismatch("cam_href_o high cycles",
                                                                   ACTIVE_CYC, cnt);
                            case (exp_pat)
                                cam_pkg::PAT_RAMP:    ramp_frames++;
                                cam_pkg::PAT_BARS:    bars_frames++;
                                cam_pkg::PAT_CHECKER: checker_frames++;
                                default: report_failure("frame sent with an unused pattern code");
                            endcase
                            phase = PH_EOF;
                            cnt   = 1;
                        end
                    end
                    PH_EOF: cnt++;
                    default: ;
                endcase
            end
            vsync_q = cam_vsync_o;
        end
    end

    // --------------------------------------------------
    // stimulus on the falling edge
    // --------------------------------------------------
    initial begin
        s_rstn      = 1'b0;
        en_i        = 1'b1;
        pattern_sel = cam_pkg::PAT_RAMP;
        repeat (8) @(negedge cam_pclk_o);
        s_rstn = 1'b1;

        wait_href_start();  // frame 0, ramp even
        wait_href_start();  // frame 1, ramp odd
        repeat (MID_LINE) @(negedge cam_pclk_o);
        pattern_sel = cam_pkg::PAT_BARS;  // takes effect next frame
        wait_href_start();
        repeat (MID_LINE) @(negedge cam_pclk_o);
        pattern_sel = cam_pkg::PAT_CHECKER;
        wait_href_start();  // checker, odd frame
        repeat (MID_LINE) @(negedge cam_pclk_o);
        en_i = 1'b0;
        repeat (50) @(negedge cam_pclk_o);
        en_i = 1'b1;
        wait_href_start();  // checker again, even after restart
        @(negedge cam_href_o);
        repeat (20) @(negedge cam_pclk_o);

        if (ramp_frames != 2) report_failure("did not see two complete ramp frames");
        if (bars_frames != 1) report_failure("did not see one complete bars frame");
        if (checker_frames != 1) report_failure("did not see a complete checker frame");
        if (aborted_frames != 1) report_failure("disable during href was not seen");
        print_counts();
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge cam_pclk_o);
            cycle_cnt++;
        end
        $display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
        print_counts();
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/cam_pkg.sv
logic/cam_pix_if.sv
logic/cam_timing_gen.sv
logic/cam_pattern_gen.sv
logic/cam_rgb565_ser.sv
logic/cam_sensor_top.sv
tb/tb_cam_sensor.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the camera sensor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_cam_sensor \
    -Mdir "$BUILD_DIR" \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_cam_sensor" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
